// File: obi_pkg.sv
// OBI bus widths and request/response structs, imported by the arbiter, RAM, top level and testbench
`default_nettype none

package obi_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int unsigned OBI_ADDR_WIDTH = 32;
    localparam int unsigned OBI_DATA_WIDTH = 32;
    // One enable per byte lane
    localparam int unsigned OBI_BE_WIDTH   = OBI_DATA_WIDTH / 8;

    // --------------------
    // Request and response structs
    // --------------------

    // Instruction port, read only, so no we/be/wdata
    typedef struct packed {
        logic                      req;
        logic [OBI_ADDR_WIDTH-1:0] addr;
    } obi_ireq_t;

    // Data port request, also the request format at the RAM
    typedef struct packed {
        logic                      req;
        logic                      we;
        logic [OBI_BE_WIDTH-1:0]   be;
        logic [OBI_ADDR_WIDTH-1:0] addr;
        logic [OBI_DATA_WIDTH-1:0] wdata;
    } obi_dreq_t;

    // Shared response, rvalid is never back-pressured
    typedef struct packed {
        logic                      gnt;
        logic                      rvalid;
        logic [OBI_DATA_WIDTH-1:0] rdata;
    } obi_rsp_t;

    // Owner of a granted request
    typedef enum logic {
        PORT_INSTR = 1'b0,
        PORT_DATA  = 1'b1
    } obi_port_e;

endpackage : obi_pkg

`default_nettype wire

// File: irq_pkg.sv
// Interrupt line count and id types, imported by the interrupt block, top level and testbench
`default_nettype none

package irq_pkg;

    // --------------------
    // Interrupt sizing
    // --------------------

    // Lines per source, both sources have the same count
    localparam int unsigned IRQ_NUM      = 32;
    // Enough bits to index any line
    localparam int unsigned IRQ_ID_WIDTH = $clog2(IRQ_NUM);

    // One bit per interrupt line
    typedef logic [IRQ_NUM-1:0] irq_vec_t;

    // Index of a single line
    typedef logic [IRQ_ID_WIDTH-1:0] irq_id_t;

endpackage : irq_pkg

`default_nettype wire

// File: obi_arbiter.sv
// Round-robin OBI arbiter, puts the instruction and data ports onto the one RAM port
`timescale 1ns/1ps
`default_nettype none

module obi_arbiter (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // Manager side
    input  obi_pkg::obi_ireq_t instr_req_i,
    input  obi_pkg::obi_dreq_t data_req_i,
    output obi_pkg::obi_rsp_t  instr_rsp_o,
    output obi_pkg::obi_rsp_t  data_rsp_o,
    // RAM side
    output obi_pkg::obi_dreq_t ram_req_o,
    input  obi_pkg::obi_rsp_t  ram_rsp_i
);

    import obi_pkg::*;

    // Port granted most recently, decides ties
    obi_port_e last_q;
    // Port selected this cycle
    obi_port_e sel;
    // Owner of the request that the RAM answers this cycle
    obi_port_e owner_q;
    // Handshake at the RAM port
    logic      grant;

    // --------------------
    // Port selection
    // --------------------
    always_comb begin
        unique case ({instr_req_i.req, data_req_i.req})
            // Tie goes to the port that was not granted last
            2'b11:   sel = (last_q == PORT_INSTR) ? PORT_DATA : PORT_INSTR;
            2'b10:   sel = PORT_INSTR;
            2'b01:   sel = PORT_DATA;
            // Idle, the choice does not matter
            default: sel = last_q;
        endcase
    end

    // Forward the selected request
    always_comb begin
        if (sel == PORT_DATA) begin
            ram_req_o = data_req_i;
        end else begin
            // Instruction bus is read only, widen to a full-word read
            ram_req_o.req   = instr_req_i.req;
            ram_req_o.we    = 1'b0;
            ram_req_o.be    = '1;
            ram_req_o.addr  = instr_req_i.addr;
            ram_req_o.wdata = '0;
        end
    end

    assign grant = ram_req_o.req & ram_rsp_i.gnt;

    // --------------------
    // Round-robin and owner state
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Instruction counts as last, so data wins the first tie
            last_q  <= PORT_INSTR;
            owner_q <= PORT_INSTR;
        end else begin
            if (grant) begin
                last_q <= sel;
            end
            // Only looked at together with the RAM's rvalid
            owner_q <= sel;
        end
    end

    // --------------------
    // Responses back to the managers
    // --------------------
    always_comb begin
        // Grant goes back only to the selected port
        instr_rsp_o.gnt    = grant & (sel == PORT_INSTR);
        data_rsp_o.gnt     = grant & (sel == PORT_DATA);
        // Read data steered by the owner of the previous grant
        instr_rsp_o.rvalid = ram_rsp_i.rvalid & (owner_q == PORT_INSTR);
        data_rsp_o.rvalid  = ram_rsp_i.rvalid & (owner_q == PORT_DATA);
        instr_rsp_o.rdata  = instr_rsp_o.rvalid ? ram_rsp_i.rdata : '0;
        data_rsp_o.rdata   = data_rsp_o.rvalid  ? ram_rsp_i.rdata : '0;
    end

endmodule : obi_arbiter

`default_nettype wire

// File: obi_ram.sv
// Single-port word RAM with byte-enabled writes and a one-cycle OBI response
`timescale 1ns/1ps
`default_nettype none

module obi_ram #(
    parameter int unsigned RAM_ADDR_WIDTH = 12
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  obi_pkg::obi_dreq_t ram_req_i,
    output obi_pkg::obi_rsp_t  ram_rsp_o
);

    import obi_pkg::*;

    // Word count and word index width
    localparam int unsigned WORDS = (2 ** RAM_ADDR_WIDTH) / 4;
    localparam int unsigned IDX_W = RAM_ADDR_WIDTH - 2;

    // Storage
    logic [OBI_DATA_WIDTH-1:0] mem_q [WORDS];

    // Word index, upper bits and byte offset dropped so the address wraps
    logic [IDX_W-1:0]          idx;
    // Registered response
    logic                      rvalid_q;
    logic [OBI_DATA_WIDTH-1:0] rdata_q;
    // Handshake, the RAM never stalls
    logic                      access;

    assign idx    = ram_req_i.addr[RAM_ADDR_WIDTH-1:2];
    assign access = ram_req_i.req;

    // --------------------
    // Array access
    // --------------------
    always_ff @(posedge clk_i) begin
        if (access) begin
            if (ram_req_i.we) begin
                // Update only the enabled byte lanes
                for (int b = 0; b < OBI_BE_WIDTH; b++) begin
                    if (ram_req_i.be[b]) begin
                        mem_q[idx][8*b +: 8] <= ram_req_i.wdata[8*b +: 8];
                    end
                end
                // Writes answer with zero data
                rdata_q <= '0;
            end else begin
                rdata_q <= mem_q[idx];
            end
        end
    end

    // One response per accepted request, next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= access;
        end
    end

    // --------------------
    // Response
    // --------------------
    assign ram_rsp_o.gnt    = access;
    assign ram_rsp_o.rvalid = rvalid_q;
    assign ram_rsp_o.rdata  = rdata_q;

endmodule : obi_ram

`default_nettype wire

// File: irq_merge.sv
// Merges the external and virtual-peripheral interrupts and debug requests for the core
`timescale 1ns/1ps
`default_nettype none

module irq_merge (
    input  logic              clk_i,
    input  logic              arst_n_i,
    // Interrupt sources
    input  irq_pkg::irq_vec_t irq_ext_i,
    input  irq_pkg::irq_vec_t irq_vp_i,
    // Acknowledge from the core
    input  logic              irq_ack_i,
    input  irq_pkg::irq_id_t  irq_ack_id_i,
    // Merged pending state
    output irq_pkg::irq_vec_t irq_pending_o,
    output logic              irq_valid_o,
    output irq_pkg::irq_id_t  irq_id_o,
    // Debug request sources and merged request
    input  logic              debug_ext_i,
    input  logic              debug_vp_i,
    output logic              debug_req_o
);

    import irq_pkg::*;

    irq_vec_t pending_q, pending_d;
    irq_id_t  id_q, id_d;
    logic     valid_q;
    logic     debug_q;

    // --------------------
    // Next pending set
    // --------------------
    always_comb begin
        pending_d = pending_q;
        // Acknowledge first
        if (irq_ack_i) begin
            pending_d[irq_ack_id_i] = 1'b0;
        end
        // then set wins over the clear
        pending_d = pending_d | irq_ext_i | irq_vp_i;
    end

    // Priority encoder, highest line wins as it is assigned last
    always_comb begin
        id_d = '0;
        for (int i = 0; i < IRQ_NUM; i++) begin
            if (pending_d[i]) begin
                id_d = irq_id_t'(i);
            end
        end
    end

    // --------------------
    // State
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            id_q      <= '0;
            valid_q   <= 1'b0;
            debug_q   <= 1'b0;
        end else begin
            pending_q <= pending_d;
            id_q      <= id_d;
            valid_q   <= |pending_d;
            debug_q   <= debug_ext_i | debug_vp_i;
        end
    end

    assign irq_pending_o = pending_q;
    assign irq_valid_o   = valid_q;
    assign irq_id_o      = id_q;
    assign debug_req_o   = debug_q;

endmodule : irq_merge

`default_nettype wire

// File: obi_mem_subsys.sv
// Top level of the memory and interrupt subsystem, instantiated by the testbench as the DUT
`timescale 1ns/1ps
`default_nettype none

module obi_mem_subsys #(
    parameter int unsigned RAM_ADDR_WIDTH = 12
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    // OBI managers
    input  obi_pkg::obi_ireq_t instr_req_i,
    output obi_pkg::obi_rsp_t  instr_rsp_o,
    input  obi_pkg::obi_dreq_t data_req_i,
    output obi_pkg::obi_rsp_t  data_rsp_o,
    // Interrupts
    input  irq_pkg::irq_vec_t  irq_ext_i,
    input  irq_pkg::irq_vec_t  irq_vp_i,
    input  logic               irq_ack_i,
    input  irq_pkg::irq_id_t   irq_ack_id_i,
    output irq_pkg::irq_vec_t  irq_pending_o,
    output logic               irq_valid_o,
    output irq_pkg::irq_id_t   irq_id_o,
    // Debug
    input  logic               debug_ext_i,
    input  logic               debug_vp_i,
    output logic               debug_req_o
);

    import obi_pkg::*;

    // Arbiter to RAM
    obi_dreq_t ram_req;
    obi_rsp_t  ram_rsp;

    // --------------------
    // Bus path
    // --------------------
    obi_arbiter i_obi_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .instr_req_i (instr_req_i),
        .data_req_i  (data_req_i),
        .instr_rsp_o (instr_rsp_o),
        .data_rsp_o  (data_rsp_o),
        .ram_req_o   (ram_req),
        .ram_rsp_i   (ram_rsp)
    );

    obi_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) i_obi_ram (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .ram_req_i (ram_req),
        .ram_rsp_o (ram_rsp)
    );

    // --------------------
    // Interrupt and debug
    // --------------------
    irq_merge i_irq_merge (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .irq_ext_i     (irq_ext_i),
        .irq_vp_i      (irq_vp_i),
        .irq_ack_i     (irq_ack_i),
        .irq_ack_id_i  (irq_ack_id_i),
        .irq_pending_o (irq_pending_o),
        .irq_valid_o   (irq_valid_o),
        .irq_id_o      (irq_id_o),
        .debug_ext_i   (debug_ext_i),
        .debug_vp_i    (debug_vp_i),
        .debug_req_o   (debug_req_o)
    );

endmodule : obi_mem_subsys

`default_nettype wire

// File: obi_mem_subsys_props.sv
// Concurrent checks on OBI handshakes and interrupt outputs, bound into the subsystem top
`timescale 1ns/1ps
`default_nettype none

module obi_mem_subsys_props (
    input logic               clk_i,
    input logic               arst_n_i,
    input obi_pkg::obi_ireq_t instr_req_i,
    input obi_pkg::obi_rsp_t  instr_rsp_o,
    input obi_pkg::obi_dreq_t data_req_i,
    input obi_pkg::obi_rsp_t  data_rsp_o,
    input irq_pkg::irq_vec_t  irq_pending_o,
    input logic               irq_valid_o,
    input irq_pkg::irq_id_t   irq_id_o
);

    // Rvalid exactly one cycle after each grant
    a_instr_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_rsp_o.rvalid == $past(instr_rsp_o.gnt)) else $error("instr rvalid timing");
    a_data_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_rsp_o.rvalid == $past(data_rsp_o.gnt)) else $error("data rvalid timing");

    // Ungranted request held stable
    a_instr_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_req_i.req && !instr_rsp_o.gnt |=> $stable(instr_req_i))
        else $error("instr request dropped before grant");
    a_data_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        data_req_i.req && !data_rsp_o.gnt |=> $stable(data_req_i))
        else $error("data request dropped before grant");

    // Reported id always names a pending line
    a_irq_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        irq_valid_o |-> irq_pending_o[irq_id_o]) else $error("irq id not pending");

endmodule : obi_mem_subsys_props

bind obi_mem_subsys obi_mem_subsys_props i_obi_mem_subsys_props (.*);

`default_nettype wire

// File: tb_obi_mem_subsys.sv
// Directed testbench for the OBI memory and interrupt subsystem, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

module tb_obi_mem_subsys;

    import obi_pkg::*;
    import irq_pkg::*;

    // Cycles allowed for any handshake
    localparam int TIMEOUT = 20;

    logic      clk = 1'b0;
    logic      arst_n;
    obi_ireq_t ireq;
    obi_dreq_t dreq;
    obi_rsp_t  irsp;
    obi_rsp_t  drsp;
    irq_vec_t  irq_ext;
    irq_vec_t  irq_vp;
    irq_vec_t  pending;
    irq_vec_t  exp_pend;
    irq_id_t   ack_id;
    irq_id_t   id;
    logic      ack;
    logic      valid;
    logic      dbg_ext;
    logic      dbg_vp;
    logic      dbg;
    int        errors = 0;
    int        tests = 0;
    // Port that won the most recent grant, decides the next tie
    obi_port_e last_port;
    // Reference RAM by word index, and the addresses in use
    logic [31:0] model [1024];
    logic [31:0] addrs [8];

    obi_mem_subsys #(
        .RAM_ADDR_WIDTH (12)
    ) i_obi_mem_subsys (
        .clk_i (clk), .arst_n_i (arst_n),
        .instr_req_i (ireq), .instr_rsp_o (irsp),
        .data_req_i (dreq), .data_rsp_o (drsp),
        .irq_ext_i (irq_ext), .irq_vp_i (irq_vp),
        .irq_ack_i (ack), .irq_ack_id_i (ack_id),
        .irq_pending_o (pending), .irq_valid_o (valid), .irq_id_o (id),
        .debug_ext_i (dbg_ext), .debug_vp_i (dbg_vp), .debug_req_o (dbg)
    );

    always #50 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("Fail %0t: %s, got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int start);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - start);
    endtask

    // Upper bits random too, the RAM wraps them away
    function automatic logic [31:0] rand_addr();
        logic [31:0] tmp;
        tmp = $urandom();
        return {tmp[31:2], 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = nw[8*b +: 8];
        end
        return res;
    endfunction

    // One transfer, rvalid expected one cycle after the grant edge
    task automatic bus_access(input obi_port_e port, input logic we, input logic [3:0] be,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int   waits;
        logic gnt;
        logic rvalid;
        waits = 0;
        @(negedge clk);
        if (port == PORT_DATA) dreq = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
        else ireq = '{req: 1'b1, addr: addr};
        #1;
        gnt = (port == PORT_DATA) ? drsp.gnt : irsp.gnt;
        while (!gnt && waits < TIMEOUT) begin
            @(negedge clk);
            #1;
            waits++;
            gnt = (port == PORT_DATA) ? drsp.gnt : irsp.gnt;
        end
        if (!gnt) begin
            $display("Timeout at %0t, the %s port was never granted", $time, port.name());
            errors++;
        end else begin
            last_port = port;
        end
        @(negedge clk);
        rvalid = (port == PORT_DATA) ? drsp.rvalid : irsp.rvalid;
        rdata  = (port == PORT_DATA) ? drsp.rdata : irsp.rdata;
        dreq.req = 1'b0;
        ireq.req = 1'b0;
        expect_equal(32'(rvalid), 32'd1, "rvalid one cycle after grant");
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset();
        int start = errors;
        @(negedge clk);
        expect_equal({30'd0, irsp.gnt, irsp.rvalid}, 32'd0, "instr gnt/rvalid after reset");
        expect_equal({30'd0, drsp.gnt, drsp.rvalid}, 32'd0, "data gnt/rvalid after reset");
        expect_equal({30'd0, dbg, valid}, 32'd0, "debug_req/irq_valid after reset");
        expect_equal(pending, 32'd0, "irq_pending after reset");
        close_test("reset", start);
    endtask

    task automatic test_byte_enables();
        int          start = errors;
        logic [31:0] d;
        logic [31:0] rd;
        logic [3:0]  be;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = rand_addr();
            d = $urandom();
            bus_access(PORT_DATA, 1'b1, 4'hf, addrs[i], d, rd);
            expect_equal(rd, 32'd0, "write rdata");
            model[addrs[i][11:2]] = d;
        end
        for (int i = 0; i < 8; i++) begin
            be = 4'b0001 << $urandom_range(3, 0);
            d = $urandom();
            bus_access(PORT_DATA, 1'b1, be, addrs[i], d, rd);
            model[addrs[i][11:2]] = merge_bytes(model[addrs[i][11:2]], d, be);
        end
        for (int i = 0; i < 8; i++) begin
            bus_access(PORT_DATA, 1'b0, 4'hf, addrs[i], 32'd0, rd);
            expect_equal(rd, model[addrs[i][11:2]], "data read after byte writes");
        end
        close_test("byte enables", start);
    endtask

    task automatic test_fetch();
        int          start = errors;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] rd;
        for (int i = 0; i < 4; i++) begin
            a = rand_addr();
            d = $urandom();
            bus_access(PORT_DATA, 1'b1, 4'hf, a, d, rd);
            model[a[11:2]] = d;
            bus_access(PORT_INSTR, 1'b0, 4'hf, a, 32'd0, rd);
            expect_equal(rd, d, "instruction fetch");
        end
        close_test("instruction fetch", start);
    endtask

    task automatic test_pipeline();
        int start = errors;
        @(negedge clk);
        for (int i = 0; i < 9; i++) begin
            if (i > 0) begin
                expect_equal(32'(drsp.rvalid), 32'd1, "pipelined rvalid");
                expect_equal(drsp.rdata, model[addrs[i-1][11:2]], "pipelined rdata");
            end
            if (i < 8) begin
                dreq = '{req: 1'b1, we: 1'b0, be: 4'hf, addr: addrs[i], wdata: 32'd0};
                #1;
                expect_equal(32'(drsp.gnt), 32'd1, "grant every cycle");
                last_port = PORT_DATA;
                @(negedge clk);
            end
        end
        dreq.req = 1'b0;
        close_test("back-to-back", start);
    endtask

    task automatic test_contention();
        int          start = errors;
        int          ni = 0;
        int          nd = 0;
        obi_port_e   turn;
        logic [31:0] exp_rd;
        // First tie goes to the port that was not granted last
        turn = (last_port == PORT_INSTR) ? PORT_DATA : PORT_INSTR;
        @(negedge clk);
        ireq = '{req: 1'b1, addr: addrs[0]};
        dreq = '{req: 1'b1, we: 1'b0, be: 4'hf, addr: addrs[7], wdata: 32'd0};
        for (int g = 0; g < 8; g++) begin
            #1;
            expect_equal({30'd0, irsp.gnt, drsp.gnt}, (turn == PORT_DATA) ? 32'd1 : 32'd2,
                         "round-robin grant");
            last_port = turn;
            exp_rd = (turn == PORT_DATA) ? model[addrs[7-nd][11:2]] : model[addrs[ni][11:2]];
            @(negedge clk);
            if (turn == PORT_DATA) begin
                expect_equal({30'd0, irsp.rvalid, drsp.rvalid}, 32'd1, "rvalid to data port");
                expect_equal(drsp.rdata, exp_rd, "data port read under contention");
                nd++;
                // Four reads per port, a port leaves only after its last grant
                if (nd == 4) begin
                    dreq.req = 1'b0;
                end else begin
                    dreq.addr = addrs[7-nd];
                end
                turn = PORT_INSTR;
            end else begin
                expect_equal({30'd0, irsp.rvalid, drsp.rvalid}, 32'd2, "rvalid to instr port");
                expect_equal(irsp.rdata, exp_rd, "instr port read under contention");
                ni++;
                if (ni == 4) begin
                    ireq.req = 1'b0;
                end else begin
                    ireq.addr = addrs[ni];
                end
                turn = PORT_DATA;
            end
        end
        ireq.req = 1'b0;
        dreq.req = 1'b0;
        close_test("contention", start);
    endtask

    // One cycle of interrupt and debug stimulus, checked one cycle later
    task automatic irq_step(input irq_vec_t ext, input irq_vec_t vp, input logic a,
                            input irq_id_t aid, input logic de, input logic dv,
                            input irq_id_t exp_id);
        @(negedge clk);
        irq_ext = ext;
        irq_vp  = vp;
        ack     = a;
        ack_id  = aid;
        dbg_ext = de;
        dbg_vp  = dv;
        if (a) exp_pend[aid] = 1'b0;
        exp_pend = exp_pend | ext | vp;
        @(negedge clk);
        ack = 1'b0;
        expect_equal(pending, exp_pend, "irq_pending");
        expect_equal(32'(valid), 32'(|exp_pend), "irq_valid");
        if (|exp_pend) expect_equal(32'(id), 32'(exp_id), "irq_id");
        expect_equal(32'(dbg), 32'(de | dv), "debug_req");
    endtask

    task automatic test_irq_debug();
        int start = errors;
        exp_pend = '0;
        irq_step(32'h0000_0208, 32'h0002_0000, 1'b0, 5'd0, 1'b1, 1'b0, 5'd17);
        irq_step(32'h0000_0008, 32'h0, 1'b1, 5'd17, 1'b0, 1'b1, 5'd9);
        // Source of line 3 still high, so it stays pending
        irq_step(32'h0000_0008, 32'h0, 1'b1, 5'd3, 1'b1, 1'b1, 5'd9);
        irq_step(32'h0, 32'h0, 1'b1, 5'd9, 1'b0, 1'b0, 5'd3);
        irq_step(32'h0, 32'h0, 1'b1, 5'd3, 1'b0, 1'b0, 5'd0);
        close_test("interrupts and debug", start);
    endtask

    // --------------------
    // Sequence
    // --------------------
    initial begin
        void'($urandom(32'h32f7_4c3f));
        arst_n  = 1'b0;
        ireq    = '0;
        dreq    = '0;
        irq_ext = '0;
        irq_vp  = '0;
        ack     = 1'b0;
        ack_id  = '0;
        dbg_ext = 1'b0;
        dbg_vp  = 1'b0;
        // Out of reset the instruction port counts as granted last
        last_port = PORT_INSTR;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset();
        test_byte_enables();
        test_pipeline();
        test_fetch();
        test_contention();
        test_irq_debug();
        $display("Tests run %0d, checks failed %0d", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_obi_mem_subsys

`default_nettype wire

// File: flist.f
obi_pkg.sv
irq_pkg.sv
obi_arbiter.sv
obi_ram.sv
irq_merge.sv
obi_mem_subsys.sv
obi_mem_subsys_props.sv
tb_obi_mem_subsys.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_obi_mem_subsys
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "Simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)
